// ==== logic/icache_bus_pkg.sv ====
package icache_bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] word_t;    // one instruction word
    typedef logic [31:0] addr_t;    // byte address

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch side and memory side bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic  req;     // one-cycle request strobe
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;   // one-cycle response pulse
        word_t data;
    } fetch_rsp_t;

    typedef struct packed {
        logic  read;    // one-cycle read strobe
        addr_t addr;    // word aligned
    } mem_req_t;

endpackage

// ==== logic/icache_ctrl_pkg.sv ====
package icache_ctrl_pkg;

    // miss handler states
    typedef enum logic [2:0] {
        idle,
        lookup,     // repeat lookup after a line fill
        read,       // memory reads in flight
        fill,       // write staged line into victim way
        respond
    } miss_state_e;

    // words per cache line
    localparam int LINE_WORDS = 4;

endpackage

// ==== logic/line_ram.sv ====
`timescale 1ns/1ps

module line_ram #(
    parameter int width  = 32,
    parameter int height = 16
) (
    input  logic                                              clk,
    input  logic                                              load,
    input  logic [((height > 1) ? $clog2(height) : 1)-1:0]    index,
    input  logic [width-1:0]                                  data_in,
    output logic [width-1:0]                                  data_out
);

    logic [width-1:0] mem [height];

    always_ff @(posedge clk) begin
        if (load) begin
            mem[index] <= data_in;
        end
    end

    assign data_out = mem[index];   // asynchronous read

endmodule

// ==== logic/nmru_table.sv ====
`timescale 1ns/1ps

module nmru_table #(
    parameter int num_ways      = 4,
    parameter int lines_per_way = 16
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [$clog2(lines_per_way)-1:0] index,
    input  logic                             touch,
    input  logic [num_ways-1:0]              hit_vector,
    input  logic [num_ways-1:0]              valid_vector,
    output logic [num_ways-1:0]              victim_sel
);

    localparam int way_w = $clog2(num_ways);

    typedef logic [way_w-1:0] way_t;

    way_t mru [lines_per_way];      // most recently used way per index
    way_t hit_way;
    logic victim_found;

    // encode the one-hot way that was just used
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (hit_vector[i]) begin
                hit_way = way_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < lines_per_way; i++) begin
                mru[i] <= '0;
            end
        end else if (touch && |hit_vector) begin
            mru[index] <= hit_way;
        end
    end

    // lowest invalid way first, else lowest way that is not mru
    always_comb begin
        victim_sel   = '0;
        victim_found = 1'b0;
        for (int i = 0; i < num_ways; i++) begin
            if (!valid_vector[i] && !victim_found) begin
                victim_sel[i] = 1'b1;
                victim_found  = 1'b1;
            end
        end
        for (int i = 0; i < num_ways; i++) begin
            if (way_t'(i) != mru[index] && !victim_found) begin
                victim_sel[i] = 1'b1;
                victim_found  = 1'b1;
            end
        end
    end

endmodule

// ==== logic/fetch_port.sv ====
`timescale 1ns/1ps

module fetch_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  icache_bus_pkg::fetch_req_t fetch_req,
    input  logic                       done,
    output logic                       fetch_busy,
    output icache_bus_pkg::addr_t      held_addr,
    output logic                       pending
);

    logic accept;

    // a request only counts while nothing is outstanding
    assign accept = fetch_req.req && !pending;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (done) begin
            pending <= 1'b0;                // answered this cycle
        end else if (accept) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_addr <= fetch_req.addr;    // kept until done
        end
    end

    // busy tracks the outstanding fetch exactly
    assign fetch_busy = pending;

endmodule

// ==== logic/way_lookup.sv ====
`timescale 1ns/1ps

module way_lookup #(
    parameter int num_ways      = 4,
    parameter int line_bytes    = 16,
    parameter int lines_per_way = 16
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  icache_bus_pkg::addr_t                          held_addr,
    input  icache_bus_pkg::word_t                          fill_word,
    input  logic [$clog2(icache_ctrl_pkg::LINE_WORDS)-1:0] fill_slot,
    input  logic                                           fill_strobe,
    input  logic                                           line_load,
    input  logic                                           touch,
    output logic                                           hit,
    output icache_bus_pkg::word_t                          hit_word
);

    import icache_bus_pkg::*;
    import icache_ctrl_pkg::*;

    localparam int word_w   = $bits(word_t);
    localparam int addr_w   = $bits(addr_t);
    localparam int offset_w = $clog2(line_bytes);
    localparam int idx_w    = $clog2(lines_per_way);
    localparam int tag_w    = addr_w - idx_w - offset_w;
    localparam int slot_w   = $clog2(LINE_WORDS);
    localparam int line_w   = LINE_WORDS * word_w;

    typedef logic [tag_w-1:0]         tag_t;
    typedef logic [idx_w-1:0]         index_t;
    typedef logic [line_w-1:0]        line_t;
    typedef logic [lines_per_way-1:0] valid_row_t;

    tag_t       tag;
    index_t     index;
    logic [slot_w-1:0] word_sel;

    line_t      fill_line;                  // staged words of the incoming line
    line_t      hit_line;
    tag_t       tag_out   [num_ways];
    line_t      line_out  [num_ways];
    valid_row_t valid_row [num_ways];
    valid_row_t valid_next [num_ways];
    valid_row_t index_hot;

    logic [num_ways-1:0] valid_vector;
    logic [num_ways-1:0] hit_vector;
    logic [num_ways-1:0] victim_sel;
    logic [num_ways-1:0] way_load;
    logic [num_ways-1:0] valid_load;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address split and fill staging
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign tag       = held_addr[addr_w-1 -: tag_w];
    assign index     = held_addr[offset_w +: idx_w];
    assign word_sel  = held_addr[2 +: slot_w];     // word within the line
    assign index_hot = valid_row_t'(1) << index;

    always_ff @(posedge clk) begin
        if (fill_strobe) begin
            fill_line[fill_slot*word_w +: word_w] <= fill_word;
        end
    end

    assign way_load = victim_sel & {num_ways{line_load}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-way storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < num_ways; i++) begin : g_way
        line_ram #(.width(tag_w), .height(lines_per_way)) tag_ram (
            .clk      (clk),
            .load     (way_load[i]),
            .index    (index),
            .data_in  (tag),
            .data_out (tag_out[i])
        );

        line_ram #(.width(line_w), .height(lines_per_way)) data_ram (
            .clk      (clk),
            .load     (way_load[i]),
            .index    (index),
            .data_in  (fill_line),
            .data_out (line_out[i])
        );

        // valid bits of a way live in one row so reset clears them in a cycle
        assign valid_load[i] = !rst_n || way_load[i];
        assign valid_next[i] = rst_n ? (valid_row[i] | index_hot) : '0;

        line_ram #(.width(lines_per_way), .height(1)) valid_ram (
            .clk      (clk),
            .load     (valid_load[i]),
            .index    (1'b0),
            .data_in  (valid_next[i]),
            .data_out (valid_row[i])
        );

        assign valid_vector[i] = valid_row[i][index];
        assign hit_vector[i]   = valid_vector[i] && (tag_out[i] == tag);
    end

    // a line load marks the filled way as most recently used
    nmru_table #(.num_ways(num_ways), .lines_per_way(lines_per_way)) nmru_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .index        (index),
        .touch        (touch || line_load),
        .hit_vector   (line_load ? victim_sel : hit_vector),
        .valid_vector (valid_vector),
        .victim_sel   (victim_sel)
    );

    always_comb begin
        hit_line = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (hit_vector[i]) begin
                hit_line = hit_line | line_out[i];
            end
        end
    end

    assign hit      = |hit_vector;
    assign hit_word = hit_line[word_sel*word_w +: word_w];

endmodule

// ==== logic/miss_handler.sv ====
`timescale 1ns/1ps

module miss_handler #(
    parameter int line_bytes = 16
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  icache_bus_pkg::addr_t                          held_addr,
    input  logic                                           pending,
    input  logic                                           hit,
    input  icache_bus_pkg::word_t                          hit_word,
    input  logic                                           mem_ready,
    input  icache_bus_pkg::word_t                          mem_rdata,
    output icache_bus_pkg::mem_req_t                       mem_req,
    output icache_bus_pkg::word_t                          fill_word,
    output logic [$clog2(icache_ctrl_pkg::LINE_WORDS)-1:0] fill_slot,
    output logic                                           fill_strobe,
    output logic                                           line_load,
    output logic                                           touch,
    output logic                                           done,
    output icache_bus_pkg::fetch_rsp_t                     fetch_rsp
);

    import icache_bus_pkg::*;
    import icache_ctrl_pkg::*;

    localparam int offset_w = $clog2(line_bytes);
    localparam int slot_w   = $clog2(LINE_WORDS);

    miss_state_e       state;
    logic [slot_w-1:0] word_cnt;
    logic [slot_w-1:0] next_cnt;
    addr_t             line_base;
    logic              probe;

    assign line_base = {held_addr[$bits(addr_t)-1:offset_w], {offset_w{1'b0}}};
    assign next_cnt  = word_cnt + 1'b1;

    // tag compare result is looked at in these cycles
    assign probe = (state == lookup) || (state == idle && pending);

    // done goes with the hit so busy drops as the response rises
    assign touch = probe && hit;
    assign done  = probe && hit;

    // received words go straight to the line buffer
    assign fill_strobe = (state == read) && mem_ready;
    assign fill_word   = mem_rdata;
    assign fill_slot   = word_cnt;
    assign line_load   = (state == fill);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // miss FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= idle;
            word_cnt        <= '0;
            mem_req.read    <= 1'b0;
            fetch_rsp.valid <= 1'b0;
        end else begin
            mem_req.read    <= 1'b0;        // strobes last one cycle
            fetch_rsp.valid <= 1'b0;
            case (state)
                idle, lookup: begin
                    if (probe) begin
                        if (hit) begin
                            fetch_rsp.valid <= 1'b1;
                            fetch_rsp.data  <= hit_word;
                            state           <= respond;
                        end else begin
                            mem_req.read <= 1'b1;
                            mem_req.addr <= line_base;
                            word_cnt     <= '0;
                            state        <= read;
                        end
                    end
                end
                read: begin
                    if (mem_ready) begin
                        if (word_cnt == slot_w'(LINE_WORDS - 1)) begin
                            state <= fill;
                        end else begin
                            word_cnt     <= next_cnt;
                            mem_req.read <= 1'b1;   // next word of the line
                            mem_req.addr <= line_base | addr_t'({next_cnt, 2'b00});
                        end
                    end
                end
                fill: begin
                    state <= lookup;            // line is in the arrays next cycle
                end
                respond: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== logic/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
    parameter int num_ways      = 4,
    parameter int line_bytes    = 16,
    parameter int lines_per_way = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  icache_bus_pkg::fetch_req_t fetch_req,
    output logic                       fetch_busy,
    output icache_bus_pkg::fetch_rsp_t fetch_rsp,
    output icache_bus_pkg::mem_req_t   mem_req,
    input  logic                       mem_ready,
    input  icache_bus_pkg::word_t      mem_rdata
);

    import icache_bus_pkg::*;
    import icache_ctrl_pkg::*;

    addr_t held_addr;
    word_t hit_word;
    word_t fill_word;
    logic  pending;
    logic  done;
    logic  hit;
    logic  fill_strobe;
    logic  line_load;
    logic  touch;
    logic [$clog2(LINE_WORDS)-1:0] fill_slot;

    fetch_port fetch_port_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .done       (done),
        .fetch_busy (fetch_busy),
        .held_addr  (held_addr),
        .pending    (pending)
    );

    way_lookup #(
        .num_ways      (num_ways),
        .line_bytes    (line_bytes),
        .lines_per_way (lines_per_way)
    ) way_lookup_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .held_addr   (held_addr),
        .fill_word   (fill_word),
        .fill_slot   (fill_slot),
        .fill_strobe (fill_strobe),
        .line_load   (line_load),
        .touch       (touch),
        .hit         (hit),
        .hit_word    (hit_word)
    );

    miss_handler #(.line_bytes(line_bytes)) miss_handler_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .held_addr   (held_addr),
        .pending     (pending),
        .hit         (hit),
        .hit_word    (hit_word),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .fill_word   (fill_word),
        .fill_slot   (fill_slot),
        .fill_strobe (fill_strobe),
        .line_load   (line_load),
        .touch       (touch),
        .done        (done),
        .fetch_rsp   (fetch_rsp)
    );

endmodule

// ==== testbench/icache_sva.sv ====
`timescale 1ns/1ps

module icache_sva (
    input logic                       clk,
    input logic                       rst_n,
    input icache_bus_pkg::mem_req_t   mem_req,
    input logic                       mem_ready,
    input logic                       pending,
    input logic                       hit,
    input icache_bus_pkg::fetch_rsp_t fetch_rsp
);

    int   fail_count = 0;
    logic read_open;                    // a read waits for mem_ready

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_open <= 1'b0;
        end else if (mem_req.read) begin
            read_open <= 1'b1;
        end else if (mem_ready) begin
            read_open <= 1'b0;
        end
    end

    strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.read |=> !mem_req.read)
    else begin
        $error("memory read strobe lasted more than one cycle");
        fail_count++;
    end

    one_read_open: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.read |-> !read_open)
    else begin
        $error("second memory read issued before mem_ready");
        fail_count++;
    end

    // a pending request that hits is answered on the next cycle
    hit_to_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        pending && hit |=> fetch_rsp.valid)
    else begin
        $error("hit response missing one cycle after lookup");
        fail_count++;
    end

    rsp_from_hit: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp.valid |-> $past(pending && hit))
    else begin
        $error("fetch response without a hit in the previous cycle");
        fail_count++;
    end

endmodule

// ==== testbench/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

    import icache_bus_pkg::*;

    localparam int    num_random   = 48;
    localparam int    num_requests = 12 + num_random;
    localparam word_t data_key     = 32'hc0de_0000;

    logic       clk = 1'b0;
    logic       rst_n;
    fetch_req_t fetch_req;
    logic       fetch_busy;
    fetch_rsp_t fetch_rsp;
    mem_req_t   mem_req;
    logic       mem_ready = 1'b0;
    word_t      mem_rdata = '0;

    logic [31:0] lfsr = 32'h2f08d7f3;
    int          errors;
    int          mem_wait;
    int          rsp_count;
    int          req_count;
    addr_t       read_log [$];          // word addresses read for the current request

    // directory model, 16 indexes by 4 ways
    logic [23:0] model_tag   [16][4];
    bit          model_valid [16][4];
    int          model_mru   [16];

    icache_top #(.num_ways(4), .line_bytes(16), .lines_per_way(16)) dut_i (.*);

    bind miss_handler icache_sva sva_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .pending   (pending),
        .hit       (hit),
        .fetch_rsp (fetch_rsp)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic finish_run();
        int total;
        total = errors + dut_i.miss_handler_i.sva_i.fail_count;
        $display("errors: %0d in testbench checks, %0d in assertions", errors,
                 dut_i.miss_handler_i.sva_i.fail_count);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // backing memory and response monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        mem_ready = 1'b0;
        if (!rst_n) begin
            mem_wait = 0;
        end else if (mem_wait > 0) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                mem_ready = 1'b1;
                mem_rdata = read_log[$] ^ data_key;
            end
        end else if (mem_req.read) begin
            read_log.push_back(mem_req.addr);
            mem_wait = 1 + int'(lfsr_bits(2));      // 1 to 4 cycles
        end
    end

    always @(negedge clk) begin
        if (fetch_rsp.valid) begin
            rsp_count++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one fetch with hit/miss prediction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic fetch_and_check(input addr_t addr, input logic poke);
        logic [3:0]  idx;
        logic [23:0] tag;
        addr_t       base;
        int          way;
        int          cycles;
        bit          expect_hit;
        idx  = addr[7:4];
        tag  = addr[31:8];
        base = {addr[31:4], 4'h0};
        way  = -1;
        for (int w = 0; w < 4; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
                way = w;
            end
        end
        expect_hit = (way >= 0);
        if (!expect_hit) begin
            for (int w = 3; w >= 0; w--) begin
                if (!model_valid[idx][w]) begin
                    way = w;                        // lowest invalid way
                end
            end
            for (int w = 3; w >= 0 && model_valid[idx][3 - w]; w--) begin
                if (w != model_mru[idx] && model_valid[idx][0] && model_valid[idx][1]
                    && model_valid[idx][2] && model_valid[idx][3]) begin
                    way = w;                        // lowest way that is not mru
                end
            end
            model_valid[idx][way] = 1'b1;
            model_tag[idx][way]   = tag;
        end
        model_mru[idx] = way;
        read_log.delete();
        fetch_req.req  = 1'b1;
        fetch_req.addr = addr;
        req_count++;
        @(negedge clk);
        fetch_req.req = 1'b0;
        cycles        = 0;
        assert (fetch_busy) else report_mismatch("fetch_busy", 32'd1, 32'd0);
        while (!fetch_rsp.valid) begin
            if (poke && cycles == 2 && fetch_busy) begin
                fetch_req.req  = 1'b1;             // must be dropped while busy
                fetch_req.addr = addr ^ 32'h100;
            end
            @(negedge clk);
            fetch_req.req = 1'b0;
            cycles++;
        end
        assert (!fetch_busy) else report_mismatch("fetch_busy", 32'd0, 32'd1);
        assert (fetch_rsp.data == ({addr[31:2], 2'b00} ^ data_key))
        else report_mismatch("fetch_rsp.data", {addr[31:2], 2'b00} ^ data_key, fetch_rsp.data);
        if (expect_hit) begin
            assert (cycles == 1) else report_mismatch("hit latency", 32'd1, cycles);
            assert (read_log.size() == 0)
            else report_mismatch("mem_req.read count", 32'd0, read_log.size());
        end else begin
            assert (read_log.size() == 4)
            else report_mismatch("mem_req.read count", 32'd4, read_log.size());
            foreach (read_log[i]) begin
                assert (read_log[i] == base + addr_t'(4 * i))
                else report_mismatch("mem_req.addr", base + addr_t'(4 * i), read_log[i]);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        addr_t addr;
        fetch_req = '0;
        rst_n     = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (!fetch_rsp.valid && !mem_req.read && !fetch_busy)
            else report_mismatch("fetch_rsp.valid,mem_req.read,fetch_busy", 32'd0,
                                 32'({fetch_rsp.valid, mem_req.read, fetch_busy}));
        end
        fetch_and_check(32'h0000_1238, 1'b0);       // cold miss
        fetch_and_check(32'h0000_1230, 1'b0);
        fetch_and_check(32'h0000_1234, 1'b0);
        fetch_and_check(32'h0000_123c, 1'b0);
        for (int k = 0; k < 4; k++) begin
            fetch_and_check(32'h0002_0050 + addr_t'(k << 8), 1'b0);
        end
        fetch_and_check(32'h0002_0054, 1'b0);       // touch the line in way 0
        fetch_and_check(32'h0002_0458, 1'b0);       // fifth tag evicts way 1
        fetch_and_check(32'h0002_005c, 1'b0);
        assert (read_log.size() == 0)
        else report_mismatch("touched line reads", 32'd0, read_log.size());
        fetch_and_check(32'h0002_0150, 1'b0);
        assert (read_log.size() == 4)
        else report_mismatch("evicted line reads", 32'd4, read_log.size());
        for (int n = 0; n < num_random; n++) begin
            addr = 32'h0004_0000 | (lfsr_bits(3) << 8) | (lfsr_bits(2) << 4)
                 | (lfsr_bits(2) << 2);
            fetch_and_check(addr, lfsr_bits(1) != 0);
        end
        repeat (4) @(negedge clk);
        assert (rsp_count == req_count)
        else report_mismatch("response count", req_count, rsp_count);
        finish_run();
    end

    initial begin
        repeat (num_requests * 40) @(posedge clk);
        errors++;
        $display("timeout: the run did not finish within %0d cycles", num_requests * 40);
        finish_run();
    end

endmodule

// ==== list.f ====
logic/icache_bus_pkg.sv
logic/icache_ctrl_pkg.sv
logic/line_ram.sv
logic/nmru_table.sv
logic/fetch_port.sv
logic/way_lookup.sv
logic/miss_handler.sv
logic/icache_top.sv
testbench/icache_sva.sv
testbench/icache_tb.sv

// ==== Makefile ====
SRCS := $(shell cat list.f)

.PHONY: run clean

run: obj_dir/Vicache_tb
	obj_dir/Vicache_tb +verilator+error+limit+100 | tee sim.log
	grep -q "^Simulation passed$$" sim.log

obj_dir/Vicache_tb: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module icache_tb -f list.f

clean:
	rm -rf obj_dir sim.log
